// ==== verilog.f ====
design/paint_pkg.sv
design/paint_control.sv
design/pixel_router.sv
design/frame_bank.sv
design/scan_reader.sv
design/paint_top.sv
dv/paint_checker.sv
dv/paint_tb.sv

// ==== dv/paint_tb.sv ====
`timescale 1ns/1ps

module paint_tb import paint_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int NUM_CMDS   = 13;

  typedef struct packed {
    cmd_op_t            op;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               scan;   // Scan the frame once this command is done
    logic [COORD_W-1:0] cur_x;  // Cursor expected afterwards
    logic [COORD_W-1:0] cur_y;
  } cmd_entry_t;

  logic               clk;
  logic               rst;
  logic               cmd_valid;
  logic               cmd_ready;
  cmd_op_t            cmd_op;
  logic [COORD_W-1:0] cmd_x;
  logic [COORD_W-1:0] cmd_y;
  logic [COORD_W-1:0] exp_cur_x;
  logic [COORD_W-1:0] exp_cur_y;
  logic [COORD_W-1:0] cur_x;
  logic [COORD_W-1:0] cur_y;
  logic               scan_start;
  logic               scan_busy;
  logic               pix_valid;
  logic               pix_ready;
  logic [COORD_W-1:0] pix_x;
  logic [COORD_W-1:0] pix_y;
  logic [COLOR_W-1:0] pix_data;
  int                 error_count;
  int                 num_scans;
  int                 watchdog_cycles;
  cmd_entry_t         cmd_table [NUM_CMDS];

  paint_top DUT (.*);

  paint_checker u_checker (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    #1;
    pix_ready = ($urandom % 3) != 0;  // Ready about two thirds of the time
  end

  function automatic cmd_entry_t make_entry(cmd_op_t op, int x, int y, bit scan,
                                            int cx, int cy);
    cmd_entry_t e;
    e.op    = op;
    e.x     = COORD_W'(x);
    e.y     = COORD_W'(y);
    e.scan  = scan;
    e.cur_x = COORD_W'(cx);
    e.cur_y = COORD_W'(cy);
    return e;
  endfunction

  // Called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_command(input cmd_entry_t e);
    cmd_valid = 1'b1;
    cmd_op    = e.op;
    cmd_x     = e.x;
    cmd_y     = e.y;
    exp_cur_x = e.cur_x;
    exp_cur_y = e.cur_y;
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic run_scan();
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);  // Last write reaches the bank
    #1;
    scan_start = 1'b1;
    @(posedge clk);
    #1;
    scan_start = 1'b0;
    while (scan_busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    pix_ready  = ($urandom(32'h2be5) % 3) != 0;  // First draw also seeds the generator
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_op     = OP_MOVE;
    cmd_x      = '0;
    cmd_y      = '0;
    exp_cur_x  = '0;
    exp_cur_y  = '0;
    scan_start = 1'b0;
    cmd_table[0]  = make_entry(OP_MOVE,     0,  0, 1,  0,  0);
    cmd_table[1]  = make_entry(OP_PAINT,    5,  3, 0,  5,  3);
    cmd_table[2]  = make_entry(OP_PALETTE, 10,  7, 0,  5,  3);
    cmd_table[3]  = make_entry(OP_PAINT,    0,  3, 0,  0,  3);
    cmd_table[4]  = make_entry(OP_PAINT,   15,  4, 0, 15,  4);
    cmd_table[5]  = make_entry(OP_PALETTE,  3, 12, 0, 15,  4);
    cmd_table[6]  = make_entry(OP_PAINT,   15, 11, 0, 15, 11);
    cmd_table[7]  = make_entry(OP_PAINT,    0, 12, 0,  0, 12);
    cmd_table[8]  = make_entry(OP_MOVE,     9,  9, 1,  9,  9);
    cmd_table[9]  = make_entry(OP_PALETTE,  5,  5, 0,  9,  9);
    cmd_table[10] = make_entry(OP_PAINT,   15, 11, 0, 15, 11);
    cmd_table[11] = make_entry(OP_PAINT,    0,  3, 0,  0,  3);
    cmd_table[12] = make_entry(OP_MOVE,     2, 14, 1,  2, 14);
    num_scans = 0;
    for (int i = 0; i < NUM_CMDS; i++) begin
      num_scans += cmd_table[i].scan;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NUM_CMDS; i++) begin
      send_command(cmd_table[i]);
      if (cmd_table[i].scan) begin
        run_scan();
      end
    end
    repeat (4) @(posedge clk);
    $display("Run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    @(negedge rst);
    watchdog_cycles = NUM_CMDS * 10 + num_scans * FRAME_W * FRAME_H * 4 + 100;
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== dv/paint_checker.sv ====
`timescale 1ns/1ps

module paint_checker import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_valid,
  input  logic               cmd_ready,
  input  cmd_op_t            cmd_op,
  input  logic [COORD_W-1:0] cmd_x,
  input  logic [COORD_W-1:0] cmd_y,
  input  logic [COORD_W-1:0] exp_cur_x,
  input  logic [COORD_W-1:0] exp_cur_y,
  input  logic [COORD_W-1:0] cur_x,
  input  logic [COORD_W-1:0] cur_y,
  input  logic               scan_start,
  input  logic               scan_busy,
  input  logic               pix_valid,
  input  logic               pix_ready,
  input  logic [COORD_W-1:0] pix_x,
  input  logic [COORD_W-1:0] pix_y,
  input  logic [COLOR_W-1:0] pix_data,
  output int                 error_count
);

  logic [COLOR_W-1:0]                 ref_frame [FRAME_H][FRAME_W];
  logic [COLOR_W-1:0]                 ref_color;
  logic [COORD_W-1:0]                 want_x;
  logic [COORD_W-1:0]                 want_y;
  logic [COORD_W-1:0]                 seq_x;
  logic [COORD_W-1:0]                 seq_y;
  logic                               held;
  logic [2*COORD_W+COLOR_W-1:0]       held_pix;
  logic                               busy_q;
  logic                               start_q;
  int                                 cur_wait;
  int                                 pix_seen;

  initial error_count = 0;

  always @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < FRAME_H; r++) begin
        for (int c = 0; c < FRAME_W; c++) begin
          ref_frame[r][c] = '0;
        end
      end
      ref_color = '0;
      cur_wait  = 0;
      pix_seen  = 0;
      held      = 1'b0;
      busy_q    = 1'b0;
      start_q   = 1'b0;
    end else begin
      // Cursor settles on the edge after acceptance
      if (cur_wait != 0) begin
        cur_wait--;
        if (cur_wait == 0 && (cur_x != want_x || cur_y != want_y)) begin
          $display("** Error at %0t: cursor (%0d,%0d), expected (%0d,%0d)",
                   $time, cur_x, cur_y, want_x, want_y);
          error_count++;
        end
      end
      if (cmd_valid && cmd_ready) begin
        want_x   = exp_cur_x;
        want_y   = exp_cur_y;
        cur_wait = 2;
        case (cmd_op)
          OP_PAINT:   ref_frame[cmd_y][cmd_x] = ref_color;
          OP_PALETTE: ref_color = {cmd_x, cmd_y};
          default:    ;
        endcase
      end
      if (held && (!pix_valid || {pix_x, pix_y, pix_data} != held_pix)) begin
        $display("** Error at %0t: stalled pixel changed from %h to %h (valid %b)",
                 $time, held_pix, {pix_x, pix_y, pix_data}, pix_valid);
        error_count++;
      end
      held     = pix_valid && !pix_ready;
      held_pix = {pix_x, pix_y, pix_data};
      if (pix_valid && pix_ready) begin
        seq_x = COORD_W'(pix_seen % FRAME_W);  // Row-major order
        seq_y = COORD_W'(pix_seen / FRAME_W);
        if (pix_x != seq_x || pix_y != seq_y || pix_data != ref_frame[seq_y][seq_x]) begin
          $display("** Error at %0t: pixel %0d is (%0d,%0d)=%h, expected (%0d,%0d)=%h",
                   $time, pix_seen, pix_x, pix_y, pix_data, seq_x, seq_y,
                   ref_frame[seq_y][seq_x]);
          error_count++;
        end
        pix_seen++;
      end
      if (busy_q && !scan_busy) begin
        if (pix_seen != FRAME_W * FRAME_H) begin
          $display("Scan ended after %0d pixels instead of %0d", pix_seen, FRAME_W * FRAME_H);
          error_count++;
        end
        pix_seen = 0;
      end
      busy_q = scan_busy;
      if (start_q && !scan_busy) begin
        $display("Scan did not start on the edge after scan_start");
        error_count++;
      end
      start_q = scan_start && !scan_busy;
    end
  end

endmodule

// ==== design/paint_top.sv ====
`timescale 1ns/1ps

module paint_top import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  cmd_op_t            cmd_op,
  input  logic [COORD_W-1:0] cmd_x,
  input  logic [COORD_W-1:0] cmd_y,
  output logic [COORD_W-1:0] cur_x,
  output logic [COORD_W-1:0] cur_y,
  input  logic               scan_start,
  output logic               scan_busy,
  output logic               pix_valid,
  input  logic               pix_ready,
  output logic [COORD_W-1:0] pix_x,
  output logic [COORD_W-1:0] pix_y,
  output logic [COLOR_W-1:0] pix_data
);

  logic                              wr_valid;
  logic                              wr_ready;
  logic [COORD_W-1:0]                wr_x;
  logic [COORD_W-1:0]                wr_y;
  logic [COLOR_W-1:0]                wr_data;
  logic [NUM_BANKS-1:0]              bank_we;
  logic [ROW_W-1:0]                  bank_row;
  logic [COORD_W-1:0]                bank_col;
  logic [COLOR_W-1:0]                bank_wdata;
  logic                              rd_en;
  logic [COORD_W-1:0]                rd_x;
  logic [COORD_W-1:0]                rd_y;
  logic [COLOR_W-1:0]                rd_data;
  logic                              bank_rd_en;
  logic [ROW_W-1:0]                  bank_rd_row;
  logic [COORD_W-1:0]                bank_rd_col;
  logic [NUM_BANKS-1:0][COLOR_W-1:0] bank_rdata;

  paint_control u_control (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_x     (cmd_x),
    .cmd_y     (cmd_y),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_x      (wr_x),
    .wr_y      (wr_y),
    .wr_data   (wr_data),
    .cur_x     (cur_x),
    .cur_y     (cur_y)
  );

  pixel_router u_router (
    .clk         (clk),
    .rst         (rst),
    .wr_valid    (wr_valid),
    .wr_ready    (wr_ready),
    .wr_x        (wr_x),
    .wr_y        (wr_y),
    .wr_data     (wr_data),
    .bank_we     (bank_we),
    .bank_row    (bank_row),
    .bank_col    (bank_col),
    .bank_wdata  (bank_wdata),
    .rd_en       (rd_en),
    .rd_x        (rd_x),
    .rd_y        (rd_y),
    .bank_rd_en  (bank_rd_en),
    .bank_rd_row (bank_rd_row),
    .bank_rd_col (bank_rd_col),
    .bank_rdata  (bank_rdata),
    .rd_data     (rd_data)
  );

  // Each bank holds a band of consecutive rows
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    frame_bank u_bank (
      .clk     (clk),
      .rst     (rst),
      .we      (bank_we[g]),
      .wr_row  (bank_row),
      .wr_col  (bank_col),
      .wr_data (bank_wdata),
      .rd_en   (bank_rd_en),
      .rd_row  (bank_rd_row),
      .rd_col  (bank_rd_col),
      .rd_data (bank_rdata[g])
    );
  end

  scan_reader u_scan (
    .clk        (clk),
    .rst        (rst),
    .scan_start (scan_start),
    .scan_busy  (scan_busy),
    .rd_en      (rd_en),
    .rd_x       (rd_x),
    .rd_y       (rd_y),
    .rd_data    (rd_data),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_data   (pix_data)
  );

endmodule

// ==== design/scan_reader.sv ====
`timescale 1ns/1ps

module scan_reader import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               scan_start,
  output logic               scan_busy,
  output logic               rd_en,
  output logic [COORD_W-1:0] rd_x,
  output logic [COORD_W-1:0] rd_y,
  input  logic [COLOR_W-1:0] rd_data,
  output logic               pix_valid,
  input  logic               pix_ready,
  output logic [COORD_W-1:0] pix_x,
  output logic [COORD_W-1:0] pix_y,
  output logic [COLOR_W-1:0] pix_data
);

  logic [COORD_W-1:0] issue_x;
  logic [COORD_W-1:0] issue_y;
  logic               all_issued;
  logic               slot_free;

  assign slot_free = !pix_valid || pix_ready;
  assign rd_en     = scan_busy && !all_issued && slot_free;
  assign rd_x      = issue_x;
  assign rd_y      = issue_y;

  // Bank output stays put under stall since no new read goes out
  assign pix_data = rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_busy  <= 1'b0;
      all_issued <= 1'b0;
      issue_x    <= '0;
      issue_y    <= '0;
    end else if (!scan_busy) begin
      if (scan_start) begin
        scan_busy  <= 1'b1;
        all_issued <= 1'b0;
        issue_x    <= '0;
        issue_y    <= '0;
      end
    end else begin
      if (rd_en) begin
        if (issue_x == COORD_W'(FRAME_W - 1)) begin
          issue_x <= '0;
          if (issue_y == COORD_W'(FRAME_H - 1)) begin
            all_issued <= 1'b1;
          end else begin
            issue_y <= issue_y + 1'b1;
          end
        end else begin
          issue_x <= issue_x + 1'b1;
        end
      end
      if (all_issued && pix_valid && pix_ready) begin
        scan_busy <= 1'b0;  // Last pixel taken
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pix_valid <= 1'b0;
    end else if (slot_free) begin
      pix_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      pix_x <= rd_x;
      pix_y <= rd_y;
    end
  end

endmodule

// ==== design/frame_bank.sv ====
`timescale 1ns/1ps

module frame_bank import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               we,
  input  logic [ROW_W-1:0]   wr_row,
  input  logic [COORD_W-1:0] wr_col,
  input  logic [COLOR_W-1:0] wr_data,
  input  logic               rd_en,
  input  logic [ROW_W-1:0]   rd_row,
  input  logic [COORD_W-1:0] rd_col,
  output logic [COLOR_W-1:0] rd_data
);

  logic [COLOR_W-1:0] mem [BANK_ROWS][FRAME_W];

  // Frame starts black after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < BANK_ROWS; r++) begin
        for (int c = 0; c < FRAME_W; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else if (we) begin
      mem[wr_row][wr_col] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row][rd_col];  // Holds while idle
    end
  end

endmodule

// ==== design/pixel_router.sv ====
`timescale 1ns/1ps

module pixel_router import paint_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               wr_valid,
  output logic                               wr_ready,
  input  logic [COORD_W-1:0]                 wr_x,
  input  logic [COORD_W-1:0]                 wr_y,
  input  logic [COLOR_W-1:0]                 wr_data,
  output logic [NUM_BANKS-1:0]               bank_we,
  output logic [ROW_W-1:0]                   bank_row,
  output logic [COORD_W-1:0]                 bank_col,
  output logic [COLOR_W-1:0]                 bank_wdata,
  input  logic                               rd_en,
  input  logic [COORD_W-1:0]                 rd_x,
  input  logic [COORD_W-1:0]                 rd_y,
  output logic                               bank_rd_en,
  output logic [ROW_W-1:0]                   bank_rd_row,
  output logic [COORD_W-1:0]                 bank_rd_col,
  input  logic [NUM_BANKS-1:0][COLOR_W-1:0]  bank_rdata,
  output logic [COLOR_W-1:0]                 rd_data
);

  logic [BANK_SEL_W-1:0] rd_bank_q;

  assign wr_ready = 1'b1;  // Stage drains into the banks every cycle

  // One-hot enable from the upper row bits
  always_ff @(posedge clk) begin
    if (rst) begin
      bank_we <= '0;
    end else begin
      bank_we <= '0;
      if (wr_valid && wr_ready) begin
        bank_we[wr_y[COORD_W-1 -: BANK_SEL_W]] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid && wr_ready) begin
      bank_row   <= wr_y[ROW_W-1:0];
      bank_col   <= wr_x;
      bank_wdata <= wr_data;
    end
  end

  assign bank_rd_en  = rd_en;
  assign bank_rd_row = rd_y[ROW_W-1:0];
  assign bank_rd_col = rd_x;

  // Bank index follows the read so the returning data can be picked
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_bank_q <= '0;
    end else if (rd_en) begin
      rd_bank_q <= rd_y[COORD_W-1 -: BANK_SEL_W];
    end
  end

  assign rd_data = bank_rdata[rd_bank_q];

endmodule

// ==== design/paint_control.sv ====
`timescale 1ns/1ps

module paint_control import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  cmd_op_t            cmd_op,
  input  logic [COORD_W-1:0] cmd_x,
  input  logic [COORD_W-1:0] cmd_y,
  output logic               wr_valid,
  input  logic               wr_ready,
  output logic [COORD_W-1:0] wr_x,
  output logic [COORD_W-1:0] wr_y,
  output logic [COLOR_W-1:0] wr_data,
  output logic [COORD_W-1:0] cur_x,
  output logic [COORD_W-1:0] cur_y
);

  paint_state_t       state;
  cmd_op_t            op_q;
  logic [COORD_W-1:0] x_q;
  logic [COORD_W-1:0] y_q;
  logic [COLOR_W-1:0] color;

  assign cmd_ready = (state == ST_IDLE);
  assign wr_valid  = (state == ST_WRITE);

  // Paint target comes from the held command, color from the current palette
  assign wr_x    = x_q;
  assign wr_y    = y_q;
  assign wr_data = color;

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      op_q <= cmd_op;
      x_q  <= cmd_x;
      y_q  <= cmd_y;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      cur_x <= '0;
      cur_y <= '0;
      color <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_valid) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (op_q == OP_PALETTE) begin
            color <= {x_q, y_q};  // Cursor stays put
          end else begin
            cur_x <= x_q;
            cur_y <= y_q;
          end
          state <= (op_q == OP_PAINT) ? ST_WRITE : ST_IDLE;
        end
        ST_WRITE: begin
          if (wr_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== design/paint_pkg.sv ====
package paint_pkg;

  // Frame geometry
  localparam int COORD_W = 4;
  localparam int FRAME_W = 16;
  localparam int FRAME_H = 16;
  localparam int COLOR_W = 8;

  // Bank split of the frame rows
  localparam int NUM_BANKS  = 4;
  localparam int BANK_ROWS  = 4;
  localparam int BANK_SEL_W = 2;  // Upper bits of y
  localparam int ROW_W      = 2;  // Lower bits of y

  typedef enum logic [1:0] {
    OP_MOVE,
    OP_PAINT,
    OP_PALETTE
  } cmd_op_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_WRITE
  } paint_state_t;

endpackage
